// File: dispatch.f
+incdir+source
source/dispatch_pkg.sv
source/lane_stat_if.sv
source/dispatch_regs.sv
source/lane_select.sv
source/demux_bus.sv
source/lane_counters.sv
source/dispatch_top.sv
bench/dispatch_tb.sv

// File: Makefile
# Verilator build of the dispatcher testbench

SRCS := $(shell grep -v '^+' dispatch.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
obj_dir/Vdispatch_tb: dispatch.f $(SRCS) source/dispatch_params.svh
	verilator --binary -f dispatch.f --top-module dispatch_tb -o Vdispatch_tb

# Pass is decided by the pass message in the simulator output
run: obj_dir/Vdispatch_tb
	@out="$$(./obj_dir/Vdispatch_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: bench/dispatch_tb.sv
// ----------------------------------------
// Directed tests of the dispatcher through its item and APB ports
// Expected statistics come from a lane model kept in the testbench
// Stops at the first mismatch
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_params.svh"

module dispatch_tb;

	import dispatch_pkg::*;

	localparam int LANES         = `DISPATCH_LANES;
	localparam int DRAIN_TIMEOUT = 100;
	localparam int APB_TIMEOUT   = 20;

	logic      clock;
	logic      rstn;
	logic      item_valid;
	vertex_t   item_vertex;
	value_t    item_value;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;

	// Lane model
	count_t exp_count [LANES];
	sum_t   exp_sum   [LANES];
	count_t exp_dropped;
	logic   model_enable;
	int     model_shift;

	logic [31:0] rng_state = 32'd99;

	dispatch_top DUT (
		.clock      (clock),
		.rstn       (rstn),
		.item_valid (item_valid),
		.item_vertex(item_vertex),
		.item_value (item_value),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	// xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Count word of lane k, sum word 4 bytes above
	function automatic apb_addr_t lane_addr(input int k, input bit sum);
		return apb_addr_t'(`DISPATCH_REG_LANE_BASE + 8 * k + (sum ? 4 : 0));
	endfunction

	task automatic check(input apb_data_t actual, input apb_data_t expected,
			input string msg);
		if (actual !== expected) begin
			$display("error at %0d ns: %s, got %h, expected %h",
				$time, msg, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string msg);
		$display("timeout at %0d ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	endtask

	task automatic clear_model();
		for (int k = 0; k < LANES; k++) begin
			exp_count[k] = '0;
			exp_sum[k]   = '0;
		end
		exp_dropped = '0;
	endtask

	// Wait until no item has been driven for 5 cycles and the lanes are quiet
	task automatic drain_pipeline();
		int quiet;
		int waited;
		quiet  = 0;
		waited = 0;
		while (quiet < 5) begin
			@(negedge clock);
			waited++;
			if (waited > DRAIN_TIMEOUT) begin
				report_timeout("pipeline did not drain");
			end
			if (!item_valid && DUT.lane_valid == '0) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
	endtask

	// ----------------------------------------
	// APB
	// ----------------------------------------

	// Setup cycle, then access cycle until pready, sampled at the falling edge
	task automatic apb_transfer(input logic write, input apb_addr_t addr,
			input apb_data_t wdata, output apb_data_t rdata, output logic err);
		int waited;
		@(posedge clock);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		waited = 0;
		while (pready !== 1'b1) begin
			if (waited == APB_TIMEOUT) begin
				report_timeout("APB transfer never completed");
			end
			@(negedge clock);
			waited++;
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clock);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
			input logic exp_err);
		apb_data_t rdata;
		logic      err;
		apb_transfer(1'b1, addr, data, rdata, err);
		check(apb_data_t'(err), apb_data_t'(exp_err),
			$sformatf("pslverr on write to %h", addr));
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
			input logic exp_err);
		logic err;
		drain_pipeline();
		apb_transfer(1'b0, addr, '0, data, err);
		check(apb_data_t'(err), apb_data_t'(exp_err),
			$sformatf("pslverr on read of %h", addr));
	endtask

	// ----------------------------------------
	// Item stream
	// ----------------------------------------

	// One item per call, model updated by the lane rule
	task automatic send_item(input vertex_t vertex, input value_t value);
		int lane;
		@(posedge clock);
		item_valid  <= 1'b1;
		item_vertex <= vertex;
		item_value  <= value;
		if (model_enable) begin
			lane = int'((vertex >> model_shift) % LANES);
			exp_count[lane] = exp_count[lane] + 32'd1;
			exp_sum[lane]   = exp_sum[lane] + value;
		end else begin
			exp_dropped = exp_dropped + 32'd1;
		end
	endtask

	task automatic stop_items();
		@(posedge clock);
		item_valid <= 1'b0;
	endtask

	// All lanes and DROPPED against the model
	task automatic check_stats(input string tag);
		apb_data_t rdata;
		for (int k = 0; k < LANES; k++) begin
			apb_read(lane_addr(k, 1'b0), rdata, 1'b0);
			check(rdata, exp_count[k], $sformatf("%s lane %0d count", tag, k));
			apb_read(lane_addr(k, 1'b1), rdata, 1'b0);
			check(rdata, exp_sum[k], $sformatf("%s lane %0d sum", tag, k));
		end
		apb_read(`DISPATCH_REG_DROPPED, rdata, 1'b0);
		check(rdata, exp_dropped, $sformatf("%s dropped", tag));
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic test_reset_values();
		apb_data_t rdata;
		apb_read(`DISPATCH_REG_CTRL, rdata, 1'b0);
		check(rdata, 32'h0, "ctrl after reset");
		check_stats("reset");
	endtask

	task automatic test_random_shift0();
		apb_data_t rdata;
		apb_write(`DISPATCH_REG_CTRL, 32'h1, 1'b0);
		model_enable = 1'b1;
		model_shift  = 0;
		apb_read(`DISPATCH_REG_CTRL, rdata, 1'b0);
		check(rdata, 32'h1, "ctrl enable");
		// Some zero values, still counted
		for (int i = 0; i < 200; i++) begin
			send_item(next_rand(), (i % 25 == 0) ? '0 : next_rand());
		end
		stop_items();
		check_stats("shift 0");
	endtask

	task automatic test_shift4();
		apb_data_t rdata;
		vertex_t   base;
		int        lane;
		apb_write(`DISPATCH_REG_CTRL, 32'h1 | (32'd4 << 8), 1'b0);
		model_enable = 1'b1;
		model_shift  = 4;
		apb_read(`DISPATCH_REG_CTRL, rdata, 1'b0);
		check(rdata, 32'h401, "ctrl shift 4");
		// 16 ids that differ only in bits 3..0
		base = next_rand() & 32'hFFFF_FFF0;
		lane = int'((base >> 4) % LANES);
		for (int j = 0; j < 16; j++) begin
			send_item(base | vertex_t'(j), next_rand());
		end
		stop_items();
		apb_read(lane_addr(lane, 1'b0), rdata, 1'b0);
		check(rdata, exp_count[lane], "shift 4 group in one lane");
		for (int i = 0; i < 100; i++) begin
			send_item(next_rand(), next_rand());
		end
		stop_items();
		check_stats("shift 4");
	endtask

	task automatic test_disabled_drops();
		apb_write(`DISPATCH_REG_CTRL, 32'h0, 1'b0);
		model_enable = 1'b0;
		model_shift  = 0;
		for (int i = 0; i < 50; i++) begin
			send_item(next_rand(), next_rand());
		end
		stop_items();
		check_stats("disabled");
	endtask

	task automatic test_clear_and_errors();
		apb_data_t rdata;
		apb_write(`DISPATCH_REG_CLEAR, 32'h1, 1'b0);
		clear_model();
		check_stats("clear");
		// Unmapped, past the lane window, and read-only targets
		apb_read(12'h00C, rdata, 1'b1);
		apb_read(lane_addr(LANES, 1'b0), rdata, 1'b1);
		apb_write(`DISPATCH_REG_DROPPED, 32'h5, 1'b1);
		apb_write(lane_addr(0, 1'b0), 32'h7, 1'b1);
		apb_read(`DISPATCH_REG_DROPPED, rdata, 1'b0);
		check(rdata, 32'h0, "dropped after rejected write");
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		rstn        = 1'b0;
		item_valid  = 1'b0;
		item_vertex = '0;
		item_value  = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		model_enable = 1'b0;
		model_shift  = 0;
		clear_model();

		repeat (10) @(posedge clock);
		rstn <= 1'b1;

		test_reset_values();
		test_random_shift0();
		test_shift4();
		test_disabled_drops();
		test_clear_and_errors();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/dispatch_top.sv
// ----------------------------------------
// Dispatcher top, item stream in, APB for control and statistics
// No back-pressure, one item per cycle accepted or dropped
// 5 cycles from an item to its counter update
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_params.svh"

module dispatch_top (
	input  logic                   clock,
	input  logic                   rstn,
	// Item stream
	input  logic                   item_valid,
	input  dispatch_pkg::vertex_t  item_vertex,
	input  dispatch_pkg::value_t   item_value,
	// APB
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  dispatch_pkg::apb_addr_t paddr,
	input  dispatch_pkg::apb_data_t pwdata,
	output dispatch_pkg::apb_data_t prdata,
	output logic                   pready,
	output logic                   pslverr
);

	import dispatch_pkg::*;

	// Control from the registers
	logic      enable;
	shift_t    shift;
	count_t    dropped_count;

	// Selected item
	logic      sel_valid;
	lane_idx_t sel_lane;
	value_t    sel_value;

	// Lane outputs
	logic [`DISPATCH_LANES-1:0] lane_valid;
	value_t                     lane_data [`DISPATCH_LANES];

	lane_stat_if stat_if ();

	// ----------------------------------------
	// Register block
	// ----------------------------------------
	dispatch_regs u_regs (
		.clock        (clock),
		.rstn         (rstn),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.enable       (enable),
		.shift        (shift),
		.dropped_count(dropped_count),
		.stat         (stat_if.regs_side)
	);

	// ----------------------------------------
	// Datapath
	// ----------------------------------------
	lane_select u_select (
		.clock        (clock),
		.rstn         (rstn),
		.item_valid   (item_valid),
		.item_vertex  (item_vertex),
		.item_value   (item_value),
		.enable       (enable),
		.shift        (shift),
		.clear        (stat_if.clear),
		.sel_valid    (sel_valid),
		.sel_lane     (sel_lane),
		.sel_value    (sel_value),
		.dropped_count(dropped_count)
	);

	demux_bus #(
		.DATA_WIDTH(`DISPATCH_VALUE_WIDTH),
		.BUS_WIDTH (`DISPATCH_LANES)
	) u_demux (
		.clock     (clock),
		.rstn      (rstn),
		.enabled_in(sel_valid),
		.sel_in    (sel_lane),
		.data_in   (sel_value),
		.data_out  (lane_data),
		.valid_out (lane_valid)
	);

	lane_counters u_counters (
		.clock     (clock),
		.rstn      (rstn),
		.lane_valid(lane_valid),
		.lane_data (lane_data),
		.stat      (stat_if.counter_side)
	);

endmodule

`default_nettype wire

// File: source/lane_counters.sv
// ----------------------------------------
// Per-lane item count and wrapping value sum
// Clear drops any update arriving in the same cycle
// Read port is combinational on rd_lane
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_params.svh"

module lane_counters (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic [`DISPATCH_LANES-1:0] lane_valid,
	input  dispatch_pkg::value_t lane_data [`DISPATCH_LANES],
	lane_stat_if.counter_side    stat
);

	import dispatch_pkg::*;

	count_t count_q [`DISPATCH_LANES];
	sum_t   sum_q   [`DISPATCH_LANES];

	// ----------------------------------------
	// Counter update
	// ----------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int k = 0; k < `DISPATCH_LANES; k++) begin
				count_q[k] <= '0;
				sum_q[k]   <= '0;
			end
		end else if (stat.clear) begin
			// Clear all lanes at once
			for (int k = 0; k < `DISPATCH_LANES; k++) begin
				count_q[k] <= '0;
				sum_q[k]   <= '0;
			end
		end else begin
			for (int k = 0; k < `DISPATCH_LANES; k++) begin
				// At most one item per lane per cycle
				if (lane_valid[k]) begin
					count_q[k] <= count_q[k] + count_t'(1);
					sum_q[k]   <= sum_q[k] + sum_t'(lane_data[k]);
				end
			end
		end
	end

	// ----------------------------------------
	// Statistics read
	// ----------------------------------------
	assign stat.rd_count = count_q[stat.rd_lane];
	assign stat.rd_sum   = sum_q[stat.rd_lane];

endmodule

`default_nettype wire

// File: source/demux_bus.sv
// ----------------------------------------
// Pipelined one-to-N demux, 3 cycles from input to lane outputs
// BUS_WIDTH must be at least 2
// valid_out marks the lane, so zero data still counts
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module demux_bus #(
	parameter int  DATA_WIDTH = 32,
	parameter int  BUS_WIDTH  = 8,
	localparam int SEL_WIDTH  = $clog2(BUS_WIDTH)
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  logic [SEL_WIDTH-1:0]  sel_in,
	input  logic [DATA_WIDTH-1:0] data_in,
	output logic [DATA_WIDTH-1:0] data_out [BUS_WIDTH],
	output logic [BUS_WIDTH-1:0]  valid_out
);

	logic                  enabled;
	logic                  valid_latched;
	logic [SEL_WIDTH-1:0]  sel_internal;
	logic [SEL_WIDTH-1:0]  sel_latched;
	logic [DATA_WIDTH-1:0] data_internal;
	logic [DATA_WIDTH-1:0] data_latched;
	logic [DATA_WIDTH-1:0] data_decoded [BUS_WIDTH];
	logic [BUS_WIDTH-1:0]  valid_decoded;

	// ----------------------------------------
	// Stage 1 and 2, input and latch
	// ----------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled       <= 1'b0;
			valid_latched <= 1'b0;
		end else begin
			enabled       <= enabled_in;
			valid_latched <= enabled;
		end
	end

	always_ff @(posedge clock) begin
		sel_internal  <= sel_in;
		data_internal <= data_in;
		// Idle cycles park on lane 0 with zero data
		if (enabled) begin
			sel_latched  <= sel_internal;
			data_latched <= data_internal;
		end else begin
			sel_latched  <= '0;
			data_latched <= '0;
		end
	end

	// ----------------------------------------
	// Decode to one-hot lanes
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < BUS_WIDTH; i++) begin
			if (sel_latched == SEL_WIDTH'(i)) begin
				data_decoded[i]  = data_latched;
				valid_decoded[i] = valid_latched;
			end else begin
				data_decoded[i]  = '0;
				valid_decoded[i] = 1'b0;
			end
		end
	end

	// Stage 3, output register
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_out <= '0;
		end else begin
			valid_out <= valid_decoded;
		end
	end

	always_ff @(posedge clock) begin
		data_out <= data_decoded;
	end

endmodule

`default_nettype wire

// File: source/lane_select.sv
// ----------------------------------------
// Input stage, one register between the item port and the demux
// Lane is (vertex >> shift) modulo the lane count
// Items seen while disabled are dropped and counted
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lane_select (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   item_valid,
	input  dispatch_pkg::vertex_t  item_vertex,
	input  dispatch_pkg::value_t   item_value,
	input  logic                   enable,
	input  dispatch_pkg::shift_t   shift,
	input  logic                   clear,
	output logic                   sel_valid,
	output dispatch_pkg::lane_idx_t sel_lane,
	output dispatch_pkg::value_t   sel_value,
	output dispatch_pkg::count_t   dropped_count
);

	import dispatch_pkg::*;

	// Valid and drop counter
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sel_valid     <= 1'b0;
			dropped_count <= '0;
		end else begin
			sel_valid <= item_valid & enable;
			// Clear wins over a drop in the same cycle
			if (clear) begin
				dropped_count <= '0;
			end else if (item_valid && !enable) begin
				dropped_count <= dropped_count + count_t'(1);
			end
		end
	end

	// Payload, qualified by sel_valid downstream
	always_ff @(posedge clock) begin
		// Truncation to the lane width is the modulo
		sel_lane  <= lane_idx_t'(item_vertex >> shift);
		sel_value <= item_value;
	end

endmodule

`default_nettype wire

// File: source/dispatch_regs.sv
// ----------------------------------------
// APB slave without wait states, pready tied high
// Clear is issued one cycle after the write access
// Unmapped addresses and writes to read-only registers raise pslverr
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_params.svh"

module dispatch_regs (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  dispatch_pkg::apb_addr_t paddr,
	input  dispatch_pkg::apb_data_t pwdata,
	output dispatch_pkg::apb_data_t prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   enable,
	output dispatch_pkg::shift_t   shift,
	input  dispatch_pkg::count_t   dropped_count,
	lane_stat_if.regs_side         stat
);

	import dispatch_pkg::*;

	localparam int        LANE_IDX_W = $bits(lane_idx_t);
	localparam int        SHIFT_LSB  = 8;
	// Bytes covered by the lane statistics window
	localparam apb_addr_t LANE_SPAN  = apb_addr_t'(8 * `DISPATCH_LANES);

	logic      access;
	logic      wr_access;
	logic      ctrl_hit;
	logic      clear_hit;
	logic      dropped_hit;
	logic      lane_hit;
	logic      mapped;
	apb_addr_t lane_off;
	logic      clear_q;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------

	// Access phase of a transfer
	assign access    = psel & penable;
	assign wr_access = access & pwrite;

	assign ctrl_hit    = (paddr == `DISPATCH_REG_CTRL);
	assign clear_hit   = (paddr == `DISPATCH_REG_CLEAR);
	assign dropped_hit = (paddr == `DISPATCH_REG_DROPPED);

	// Offset into the lane window, word aligned only
	assign lane_off = paddr - `DISPATCH_REG_LANE_BASE;
	assign lane_hit = (paddr >= `DISPATCH_REG_LANE_BASE) && (lane_off < LANE_SPAN)
		&& (lane_off[1:0] == 2'b00);

	assign mapped = ctrl_hit | clear_hit | dropped_hit | lane_hit;

	// Lane k at base + 8k, so the index sits above the count/sum bit
	assign stat.rd_lane = lane_off[3 +: LANE_IDX_W];

	// Read only are DROPPED and the lane window
	assign pslverr = access & (~mapped | (pwrite & (dropped_hit | lane_hit)));
	assign pready  = 1'b1;

	// ----------------------------------------
	// Control register and clear pulse
	// ----------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable  <= 1'b0;
			shift   <= '0;
			clear_q <= 1'b0;
		end else begin
			// Writes land at the end of the access cycle
			if (wr_access && ctrl_hit) begin
				enable <= pwdata[0];
				shift  <= pwdata[SHIFT_LSB +: $bits(shift_t)];
			end
			// Single pulse per write of 1 to CLEAR
			clear_q <= wr_access & clear_hit & pwdata[0];
		end
	end

	assign stat.clear = clear_q;

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb begin
		prdata = '0;
		if (ctrl_hit) begin
			prdata[0]                          = enable;
			prdata[SHIFT_LSB +: $bits(shift_t)] = shift;
		end else if (dropped_hit) begin
			prdata = apb_data_t'(dropped_count);
		end else if (lane_hit) begin
			// Bit 2 picks the sum word of the pair
			if (lane_off[2]) begin
				prdata = apb_data_t'(stat.rd_sum);
			end else begin
				prdata = apb_data_t'(stat.rd_count);
			end
		end
		// CLEAR and unmapped addresses read as zero
	end

endmodule

`default_nettype wire

// File: source/lane_stat_if.sv
// ----------------------------------------
// Statistics read port and clear pulse
// rd_count and rd_sum follow rd_lane in the same cycle
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface lane_stat_if;

	import dispatch_pkg::*;

	// Lane being read, from the register block
	lane_idx_t rd_lane;
	// Statistics of rd_lane, combinational from the counters
	count_t    rd_count;
	sum_t      rd_sum;
	// One-cycle pulse, zeroes every lane
	logic      clear;

	// Register block side
	modport regs_side (
		output rd_lane,
		output clear,
		input  rd_count,
		input  rd_sum
	);

	// Counter block side
	modport counter_side (
		input  rd_lane,
		input  clear,
		output rd_count,
		output rd_sum
	);

endinterface

`default_nettype wire

// File: source/dispatch_pkg.sv
// ----------------------------------------
// Types shared by the dispatcher blocks
// Counters and sums wrap silently at their width
// ----------------------------------------
`default_nettype none

`include "dispatch_params.svh"

package dispatch_pkg;

	// Item payload
	typedef logic [`DISPATCH_VERTEX_WIDTH-1:0] vertex_t;
	typedef logic [`DISPATCH_VALUE_WIDTH-1:0]  value_t;

	// Lane number, low bits of the shifted vertex id
	typedef logic [$clog2(`DISPATCH_LANES)-1:0] lane_idx_t;

	// Per-lane statistics
	typedef logic [`DISPATCH_COUNT_WIDTH-1:0] count_t;
	// Sum modulo 2**32
	typedef logic [`DISPATCH_VALUE_WIDTH-1:0] sum_t;

	// Right shift applied to the vertex id before lane selection
	typedef logic [$clog2(`DISPATCH_VERTEX_WIDTH)-1:0] shift_t;

	// ----------------------------------------
	// APB
	// ----------------------------------------
	typedef logic [`DISPATCH_APB_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [31:0]                         apb_data_t;

endpackage

`default_nettype wire

// File: source/dispatch_params.svh
// ----------------------------------------
// Lane count, datapath widths and APB register map of the dispatcher
// The lane count must be a power of two, at least 2
// Lane statistics sit at 8-byte strides from the lane base
// ----------------------------------------
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// Datapath sizing
`define DISPATCH_LANES          8
`define DISPATCH_VERTEX_WIDTH   32
`define DISPATCH_VALUE_WIDTH    32
`define DISPATCH_COUNT_WIDTH    32
`define DISPATCH_APB_ADDR_WIDTH 12

// Register map
`define DISPATCH_REG_CTRL      12'h000
`define DISPATCH_REG_CLEAR     12'h004
`define DISPATCH_REG_DROPPED   12'h008
`define DISPATCH_REG_LANE_BASE 12'h100

`endif
